// ==== s32xShSys.f ====
+incdir+design
design/s32xPkg.sv
design/shRegIf.sv
design/shBusDecoder.sv
design/irqCtrl.sv
design/pwmFifo.sv
design/pwmUnit.sv
design/s32xShSys.sv
sim/tbS32xShSys.sv

// ==== Bender.yml ====
package:
  name: s32xShSys

sources:
  - include_dirs:
      - design
    files:
      - design/s32xPkg.sv
      - design/shRegIf.sv
      - design/shBusDecoder.sv
      - design/irqCtrl.sv
      - design/pwmFifo.sv
      - design/pwmUnit.sv
      - design/s32xShSys.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tbS32xShSys.sv

// ==== sim/tbS32xShSys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module tbS32xShSys;

	localparam logic [7:0]  IMR_MASK   = `S32X_IMR_MASK;
	localparam logic [15:0] PWMCR_MASK = `S32X_PWMCR_MASK;
	localparam logic [15:0] CYCR_MASK  = `S32X_CYCR_MASK;
	localparam logic [15:0] PWR_MASK   = `S32X_PWR_MASK;

	logic        CLK;
	logic        RST_N;
	logic        CE_R;
	logic        CE_F;
	logic [17:1] SHA;
	logic [15:0] SHDI;
	wire  [15:0] SHDO;
	logic        SHCS0M_N;
	logic        SHCS0S_N;
	logic        SHBS_N;
	logic        SHRD_WR_N;
	logic        SHRD_N;
	logic        SHDQMLL_N;
	logic        SHDQMLU_N;
	wire         SHDREQ1_N;
	wire  [2:0]  SHMIRL_N;
	wire  [2:0]  SHSIRL_N;
	logic        VDP_VINT;
	logic        VDP_HINT;
	wire  [15:0] PWM_L;
	wire  [15:0] PWM_R;

	// Reference model
	logic [3:0]  mNib [2];
	logic        mHen;
	logic [7:0]  mHcntr;
	logic [7:0]  mLine;
	logic [15:0] mPwmcr;
	logic [11:0] mCycr;
	logic [11:0] mLPw;
	logic [11:0] mRPw;
	logic [11:0] lq [$];
	logic [11:0] rq [$];
	logic [11:0] heldL;
	logic [11:0] heldR;
	logic [1:0]  vP;
	logic [1:0]  hP;
	logic [1:0]  pP;
	int unsigned cePulses;
	int unsigned dreqPulses;
	int unsigned dreqLow;
	logic        dreqPrev;

	s32xShSys s32xShSys_i (.*);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(negedge CLK) begin
		CE_R <= ~CE_R; // CE_R and CE_F take turns
		CE_F <= CE_R;
	end

	always @(posedge CLK) begin
		if (CE_R) cePulses <= cePulses + 1;
	end

	always @(negedge CLK) begin
		dreqPrev <= SHDREQ1_N;
		if (!SHDREQ1_N) dreqLow <= dreqLow + 1;
		if (!SHDREQ1_N && dreqPrev) dreqPulses <= dreqPulses + 1;
	end

	task automatic failRun(input string msg);
		$display("TB FAILED");
		$display("%s", msg);
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) failRun($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic waitCe(input logic rise);
		int n;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
			if (n > 8) failRun("timeout waiting for a clock enable edge");
		end while (rise ? !CE_R : !CE_F);
	endtask

	task automatic releaseBus();
		SHCS0M_N = 1'b1;
		SHCS0S_N = 1'b1;
		SHBS_N = 1'b1;
		SHRD_WR_N = 1'b1;
		SHRD_N = 1'b1;
		SHDQMLL_N = 1'b1;
		SHDQMLU_N = 1'b1;
	endtask

	// Bus start, decoder latches the select on a CE_F edge
	task automatic startAccess(input logic slv, input logic [4:0] ofs);
		@(negedge CLK);
		SHA = {10'h040, 2'b00, ofs};
		SHCS0M_N = slv;
		SHCS0S_N = ~slv;
		SHBS_N = 1'b0;
		waitCe(1'b0);
		@(negedge CLK);
		SHBS_N = 1'b1;
	endtask

	task automatic writeReg(input logic slv, input logic [4:0] ofs, input logic [15:0] data,
			input logic [1:0] lanes);
		logic [11:0] pw;
		startAccess(slv, ofs);
		SHRD_WR_N = 1'b0;
		SHDI = data;
		SHDQMLL_N = ~lanes[0];
		SHDQMLU_N = ~lanes[1];
		waitCe(1'b0);
		@(negedge CLK);
		releaseBus();
		@(negedge CLK); // Register updated one edge after wr
		pw = data[11:0] & PWR_MASK[11:0];
		case (ofs)
			`S32X_OFS_IMR: begin
				if (lanes[0]) begin
					mNib[slv] = data[3:0] & IMR_MASK[3:0];
					mHen = data[7] & IMR_MASK[7];
				end
			end
			`S32X_OFS_HCNTR: if (lanes[0]) mHcntr = data[7:0];
			`S32X_OFS_PWMCR: begin
				if (lanes[0]) mPwmcr[7:0] = data[7:0] & PWMCR_MASK[7:0];
				if (lanes[1]) mPwmcr[15:8] = data[15:8] & PWMCR_MASK[15:8];
			end
			`S32X_OFS_CYCR: begin
				if (lanes[0]) mCycr[7:0] = data[7:0] & CYCR_MASK[7:0];
				if (lanes[1]) mCycr[11:8] = data[11:8] & CYCR_MASK[11:8];
			end
			`S32X_OFS_LPW, `S32X_OFS_RPW, `S32X_OFS_MPW: begin
				if (ofs != `S32X_OFS_RPW) begin
					mLPw = pw;
					if (lq.size() < `S32X_PWM_DEPTH) lq.push_back(pw);
				end
				if (ofs != `S32X_OFS_LPW) begin
					mRPw = pw;
					if (rq.size() < `S32X_PWM_DEPTH) rq.push_back(pw);
				end
			end
			`S32X_OFS_VCLR:   vP[slv] = 1'b0;
			`S32X_OFS_HCLR:   hP[slv] = 1'b0;
			`S32X_OFS_PWMCLR: pP[slv] = 1'b0;
			default: ;
		endcase
	endtask

	task automatic readReg(input logic slv, input logic [4:0] ofs, output logic [15:0] data);
		startAccess(slv, ofs);
		SHRD_N = 1'b0;
		waitCe(1'b1);
		@(negedge CLK);
		releaseBus();
		@(negedge CLK);
		data = SHDO;
	endtask

	function automatic logic [15:0] expRead(input logic slv, input logic [4:0] ofs);
		case (ofs)
			`S32X_OFS_IMR:   return {8'h00, mHen, 3'b000, mNib[slv]};
			`S32X_OFS_HCNTR: return {8'h00, mHcntr};
			`S32X_OFS_PWMCR: return mPwmcr;
			`S32X_OFS_CYCR:  return {4'h0, mCycr};
			`S32X_OFS_LPW,
			`S32X_OFS_MPW:   return {lq.size() == `S32X_PWM_DEPTH, lq.size() == 0, 2'b00, mLPw};
			`S32X_OFS_RPW:   return {rq.size() == `S32X_PWM_DEPTH, rq.size() == 0, 2'b00, mRPw};
			default:         return 16'h0000;
		endcase
	endfunction

	task automatic checkRead(input logic slv, input logic [4:0] ofs);
		logic [15:0] got;
		readReg(slv, ofs, got);
		checkEq($sformatf("SHDO at offset %02h", {ofs, 1'b0}), got, expRead(slv, ofs));
	endtask

	// V over H over PWM
	function automatic logic [2:0] expLevel(input int cpu);
		if (vP[cpu]) return 3'b001;
		else if (hP[cpu]) return 3'b010;
		else if (pP[cpu]) return 3'b100;
		else return 3'b111;
	endfunction

	task automatic checkLevels();
		checkEq("SHMIRL_N", SHMIRL_N, expLevel(0));
		checkEq("SHSIRL_N", SHSIRL_N, expLevel(1));
	endtask

	function automatic logic [15:0] outVal(input logic [11:0] s);
		return {s - 12'(`S32X_PWM_CENTER), 4'h0};
	endfunction

	function automatic logic [1:0] randLanes();
		return 2'(1 + $urandom % 3);
	endfunction

	task automatic setVint(input logic lvl);
		@(negedge CLK);
		for (int i = 0; i < 2; i++) begin
			if (lvl && !VDP_VINT && mNib[i][3]) vP[i] = 1'b1;
		end
		VDP_VINT = lvl;
		repeat (3) @(negedge CLK);
		checkLevels();
	endtask

	task automatic pulseHint();
		@(negedge CLK);
		VDP_HINT = 1'b1;
		repeat (3) @(negedge CLK);
		VDP_HINT = 1'b0;
		if (mLine == mHcntr) begin
			mLine = 8'd0;
			for (int i = 0; i < 2; i++) begin
				if (mNib[i][2] && (mHen || !VDP_VINT)) hP[i] = 1'b1;
			end
		end else begin
			mLine = mLine + 8'd1;
		end
		repeat (2) @(negedge CLK);
		checkLevels();
	endtask

	task automatic clearAll();
		for (int i = 0; i < 2; i++) begin
			writeReg(1'(i), `S32X_OFS_VCLR, 16'h0000, 2'b11);
			writeReg(1'(i), `S32X_OFS_HCLR, 16'h0000, 2'b11);
			writeReg(1'(i), `S32X_OFS_PWMCLR, 16'h0000, 2'b11);
		end
		checkLevels();
	endtask

	initial begin
		logic [4:0]  regOfs [4];
		logic [4:0]  pwOfs [3];
		logic        slv;
		logic        rtp;
		logic [4:0]  ofs;
		logic [15:0] rdL;
		logic [15:0] rdR;
		logic [11:0] s;
		logic [11:0] prevL;
		logic [11:0] prevR;
		int          n;
		int          cyc;
		int          tm;
		int          ticks;
		int unsigned lastCe;
		int unsigned dreqBase;
		int unsigned lowBase;

		void'($urandom(32'hf525_99fa));
		regOfs = '{`S32X_OFS_IMR, `S32X_OFS_HCNTR, `S32X_OFS_PWMCR, `S32X_OFS_CYCR};
		pwOfs = '{`S32X_OFS_LPW, `S32X_OFS_RPW, `S32X_OFS_MPW};
		RST_N = 1'b0;
		CE_R = 1'b0;
		CE_F = 1'b1;
		SHA = '0;
		SHDI = '0;
		VDP_VINT = 1'b0;
		VDP_HINT = 1'b0;
		releaseBus();
		mNib[0] = 4'h0;
		mNib[1] = 4'h0;
		mHen = 1'b0;
		mHcntr = 8'h00;
		mLine = 8'h00;
		mPwmcr = 16'h0000;
		mCycr = 12'h000;
		mLPw = 12'h000;
		mRPw = 12'h000;
		heldL = `S32X_PWM_CENTER;
		heldR = `S32X_PWM_CENTER;
		vP = '0;
		hP = '0;
		pP = '0;
		cePulses = 0;
		dreqPulses = 0;
		dreqLow = 0;
		dreqPrev = 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		checkEq("SHDREQ1_N", SHDREQ1_N, 1'b1);
		checkLevels();
		checkEq("PWM_L", PWM_L, 16'h0000);
		checkEq("PWM_R", PWM_R, 16'h0000);
		checkRead(1'b0, `S32X_OFS_LPW);
		checkRead(1'b1, `S32X_OFS_RPW);

		// Register readback, both CPUs see the shared HEN
		for (int i = 0; i < 40; i++) begin
			slv = 1'($urandom);
			ofs = regOfs[$urandom % 4];
			writeReg(slv, ofs, 16'($urandom), randLanes());
			checkRead(slv, ofs);
			checkRead(~slv, ofs);
		end
		writeReg(1'b0, `S32X_OFS_PWMCR, 16'h0000, 2'b11);
		clearAll();

		// V interrupts, with H pending underneath at times
		writeReg(1'b0, `S32X_OFS_HCNTR, 16'h0000, 2'b01);
		for (int i = 0; i < 8; i++) begin
			writeReg(1'b0, `S32X_OFS_IMR, 16'($urandom), 2'b01);
			writeReg(1'b1, `S32X_OFS_IMR, 16'($urandom), 2'b01);
			if ($urandom % 2) pulseHint();
			setVint(1'b1);
			slv = 1'($urandom);
			writeReg(slv, `S32X_OFS_VCLR, 16'($urandom), randLanes());
			checkLevels();
			setVint(1'b0);
			writeReg(~slv, `S32X_OFS_VCLR, 16'($urandom), randLanes());
			writeReg(1'b0, `S32X_OFS_HCLR, 16'h0000, 2'b11);
			writeReg(1'b1, `S32X_OFS_HCLR, 16'h0000, 2'b11);
			checkLevels();
		end

		// H interrupts every HCNTR+1 lines, gated by HEN in vblank
		for (int i = 0; i < 6; i++) begin
			n = $urandom % 4;
			writeReg(1'($urandom), `S32X_OFS_HCNTR, {8'($urandom), 8'(n)}, 2'b01);
			writeReg(1'b0, `S32X_OFS_IMR, 16'($urandom), 2'b01);
			writeReg(1'b1, `S32X_OFS_IMR, 16'($urandom), 2'b01);
			setVint(1'($urandom));
			writeReg(1'b0, `S32X_OFS_VCLR, 16'h0000, 2'b11);
			writeReg(1'b1, `S32X_OFS_VCLR, 16'h0000, 2'b11);
			repeat (2 * (n + 1)) begin
				pulseHint();
				if (hP != 2'b00) begin
					writeReg(1'b0, `S32X_OFS_HCLR, 16'h0000, 2'b11);
					writeReg(1'b1, `S32X_OFS_HCLR, 16'h0000, 2'b11);
					checkLevels();
				end
			end
			setVint(1'b0);
		end

		// FIFO flags with PWM off
		for (int i = 0; i < 10; i++) begin
			writeReg(1'($urandom), pwOfs[$urandom % 3], 16'($urandom), randLanes());
			checkRead(1'($urandom), `S32X_OFS_LPW);
			checkRead(1'($urandom), `S32X_OFS_RPW);
			checkRead(1'($urandom), `S32X_OFS_MPW);
		end

		// Drain what is left before timing the output
		writeReg(1'b0, `S32X_OFS_CYCR, 16'h0002, 2'b11);
		writeReg(1'b0, `S32X_OFS_PWMCR, 16'h0005, 2'b11);
		n = 0;
		do begin
			readReg(1'b0, `S32X_OFS_LPW, rdL);
			readReg(1'b0, `S32X_OFS_RPW, rdR);
			n++;
			if (n > 20) failRun("timeout waiting for the PWM FIFOs to drain");
		end while (!(rdL[14] && rdR[14]));
		writeReg(1'b0, `S32X_OFS_PWMCR, 16'h0000, 2'b11);
		while (lq.size() > 0) heldL = lq.pop_front();
		while (rq.size() > 0) heldR = rq.pop_front();
		clearAll();
		checkEq("PWM_L", PWM_L, outVal(heldL));
		checkEq("PWM_R", PWM_R, outVal(heldR));

		// Consecutive samples differ so each period shows on the output
		prevL = heldL;
		prevR = heldR;
		for (int k = 0; k < `S32X_PWM_DEPTH; k++) begin
			do s = 12'($urandom); while (s == prevL);
			writeReg(1'($urandom), `S32X_OFS_LPW, {4'($urandom), s}, 2'b11);
			prevL = s;
			do s = 12'($urandom); while (s == prevR);
			writeReg(1'($urandom), `S32X_OFS_RPW, {4'($urandom), s}, 2'b11);
			prevR = s;
		end
		cyc = 8 + $urandom % 8;
		tm = 1 + $urandom % 3;
		rtp = 1'($urandom);
		writeReg(1'b0, `S32X_OFS_IMR, 16'($urandom), 2'b01);
		writeReg(1'b1, `S32X_OFS_IMR, 16'($urandom), 2'b01);
		writeReg(1'b0, `S32X_OFS_CYCR, 16'(cyc), 2'b11);
		dreqBase = dreqPulses;
		lowBase = dreqLow;
		ticks = 0;
		lastCe = 0;
		writeReg(1'b1, `S32X_OFS_PWMCR, {4'h0, 4'(tm), rtp, 3'b000, 2'b01, 2'b01}, 2'b11);
		for (int k = 1; k <= `S32X_PWM_DEPTH; k++) begin
			n = 0;
			while (PWM_L == outVal(heldL)) begin
				@(negedge CLK);
				n++;
				if (n > 64) failRun("timeout waiting for a PWM period to end");
			end
			heldL = lq.pop_front();
			heldR = rq.pop_front();
			checkEq("PWM_L", PWM_L, outVal(heldL));
			checkEq("PWM_R", PWM_R, outVal(heldR));
			if (k > 1) checkEq("CE_R pulses per period", cePulses - lastCe, cyc);
			lastCe = cePulses;
			if (k % tm == 0) begin
				ticks++;
				for (int i = 0; i < 2; i++) begin
					if (mNib[i][0]) pP[i] = 1'b1;
				end
			end
			checkLevels();
		end
		writeReg(1'b0, `S32X_OFS_PWMCR, 16'h0000, 2'b11);
		repeat (4) @(negedge CLK);
		checkEq("SHDREQ1_N pulses", dreqPulses - dreqBase, rtp ? ticks : 0);
		checkEq("SHDREQ1_N low cycles", dreqLow - lowBase, rtp ? 2 * ticks : 0);
		checkEq("SHDREQ1_N", SHDREQ1_N, 1'b1);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/s32xShSys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module s32xShSys (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      CE_R,
	input  wire                      CE_F,

	input  wire               [17:1] SHA,
	input  wire  [`S32X_DATA_W-1:0]  SHDI,
	output logic [`S32X_DATA_W-1:0]  SHDO,
	input  wire                      SHCS0M_N,
	input  wire                      SHCS0S_N,
	input  wire                      SHBS_N,
	input  wire                      SHRD_WR_N,
	input  wire                      SHRD_N,
	input  wire                      SHDQMLL_N,
	input  wire                      SHDQMLU_N,
	output logic                     SHDREQ1_N,
	output s32xPkg::irqLevelT        SHMIRL_N,
	output s32xPkg::irqLevelT        SHSIRL_N,

	input  wire                      VDP_VINT,
	input  wire                      VDP_HINT,

	output logic [`S32X_DATA_W-1:0]  PWM_L,
	output logic [`S32X_DATA_W-1:0]  PWM_R
);

	wire pwmTick;

	shRegIf regBus ();

	shBusDecoder busDec (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .CE_F(CE_F),
		.SHA(SHA), .SHDI(SHDI), .SHDO(SHDO),
		.SHCS0M_N(SHCS0M_N), .SHCS0S_N(SHCS0S_N), .SHBS_N(SHBS_N),
		.SHRD_WR_N(SHRD_WR_N), .SHRD_N(SHRD_N),
		.SHDQMLL_N(SHDQMLL_N), .SHDQMLU_N(SHDQMLU_N),
		.regBus(regBus.master)
	);

	irqCtrl irq (
		.CLK(CLK), .RST_N(RST_N), .VDP_VINT(VDP_VINT), .VDP_HINT(VDP_HINT),
		.pwmTick(pwmTick), .regBus(regBus.irq),
		.SHMIRL_N(SHMIRL_N), .SHSIRL_N(SHSIRL_N)
	);

	pwmUnit pwm (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .regBus(regBus.pwm),
		.PWM_L(PWM_L), .PWM_R(PWM_R), .SHDREQ1_N(SHDREQ1_N), .pwmTick(pwmTick)
	);

endmodule

`default_nettype wire

// ==== design/pwmUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module pwmUnit (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      CE_R,

	shRegIf.pwm                      regBus,

	output logic [`S32X_DATA_W-1:0]  PWM_L,
	output logic [`S32X_DATA_W-1:0]  PWM_R,
	output logic                     SHDREQ1_N,
	output logic                     pwmTick
);

	localparam logic [15:0] PWMCR_MASK = `S32X_PWMCR_MASK;
	localparam logic [15:0] CYCR_MASK  = `S32X_CYCR_MASK;
	localparam logic [15:0] PWR_MASK   = `S32X_PWR_MASK;

	s32xPkg::pwmcrT        pwmcr;
	logic [11:0]           cycr;
	logic [`S32X_PW_W-1:0] lPw;     // Last written widths for readback
	logic [`S32X_PW_W-1:0] rPw;
	logic [11:0]           cycCnt;
	logic [3:0]            timCnt;
	logic [`S32X_PW_W-1:0] lSample;
	logic [`S32X_PW_W-1:0] rSample;
	logic [`S32X_PW_W-1:0] lHead;
	logic [`S32X_PW_W-1:0] rHead;
	logic                  lFull;
	logic                  lEmpty;
	logic                  rFull;
	logic                  rEmpty;
	logic                  reqPend;
	logic                  dreq;
	s32xPkg::pwrT          lView;
	s32xPkg::pwrT          rView;

	wire [`S32X_PW_W-1:0] pwIn = regBus.wdata[`S32X_PW_W-1:0] & PWR_MASK[`S32X_PW_W-1:0];
	wire lPush = regBus.wr && (regBus.ofs == `S32X_OFS_LPW || regBus.ofs == `S32X_OFS_MPW);
	wire rPush = regBus.wr && (regBus.ofs == `S32X_OFS_RPW || regBus.ofs == `S32X_OFS_MPW);

	wire        chanOn    = (pwmcr.lmd != 2'b00) || (pwmcr.rmd != 2'b00);
	wire [11:0] cycNext   = cycCnt + 12'd1;
	wire [3:0]  timNext   = timCnt + 4'd1;
	wire        periodEnd = CE_R && chanOn && (cycNext == cycr);
	wire        timerHit  = periodEnd && (timNext == pwmcr.tm);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pwmcr <= '0;
			cycr <= '0;
			lPw <= '0;
			rPw <= '0;
		end else if (regBus.wr) begin
			case (regBus.ofs)
				`S32X_OFS_PWMCR: begin
					if (regBus.beL) pwmcr[7:0] <= regBus.wdata[7:0] & PWMCR_MASK[7:0];
					if (regBus.beU) pwmcr[15:8] <= regBus.wdata[15:8] & PWMCR_MASK[15:8];
				end
				`S32X_OFS_CYCR: begin
					if (regBus.beL) cycr[7:0] <= regBus.wdata[7:0] & CYCR_MASK[7:0];
					if (regBus.beU) cycr[11:8] <= regBus.wdata[11:8] & CYCR_MASK[11:8];
				end
				`S32X_OFS_LPW: lPw <= pwIn;
				`S32X_OFS_RPW: rPw <= pwIn;
				`S32X_OFS_MPW: begin
					lPw <= pwIn;
					rPw <= pwIn;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt <= '0;
			timCnt <= '0;
			lSample <= `S32X_PWM_CENTER;
			rSample <= `S32X_PWM_CENTER;
			reqPend <= 1'b0;
			dreq <= 1'b0;
		end else begin
			if (!chanOn) begin
				cycCnt <= '0;
				timCnt <= '0;
			end else if (CE_R) begin
				if (cycNext == cycr) begin
					cycCnt <= '0;
					timCnt <= timerHit ? 4'd0 : timNext;
				end else begin
					cycCnt <= cycNext;
				end
			end
			if (periodEnd && !lEmpty) lSample <= lHead; // Empty FIFO holds last sample
			if (periodEnd && !rEmpty) rSample <= rHead;

			// DREQ1 lasts one CE_R period
			if (CE_R) begin
				if (reqPend) begin
					dreq <= pwmcr.rtp;
					reqPend <= 1'b0;
				end else begin
					dreq <= 1'b0;
				end
			end
			if (timerHit) reqPend <= 1'b1;
		end
	end

	pwmFifo #(.DEPTH(`S32X_PWM_DEPTH)) lFifo (
		.CLK(CLK), .RST_N(RST_N), .push(lPush), .pop(periodEnd), .din(pwIn),
		.head(lHead), .full(lFull), .empty(lEmpty)
	);

	pwmFifo #(.DEPTH(`S32X_PWM_DEPTH)) rFifo (
		.CLK(CLK), .RST_N(RST_N), .push(rPush), .pop(periodEnd), .din(pwIn),
		.head(rHead), .full(rFull), .empty(rEmpty)
	);

	assign lView = '{full: lFull, empty: lEmpty, rsv: 2'b00, pw: lPw};
	assign rView = '{full: rFull, empty: rEmpty, rsv: 2'b00, pw: rPw};

	always_comb begin
		case (regBus.ofs)
			`S32X_OFS_PWMCR: regBus.pwmRdata = pwmcr;
			`S32X_OFS_CYCR:  regBus.pwmRdata = {4'h0, cycr};
			`S32X_OFS_LPW,
			`S32X_OFS_MPW:   regBus.pwmRdata = lView; // Mono reads the left side
			`S32X_OFS_RPW:   regBus.pwmRdata = rView;
			default:         regBus.pwmRdata = '0;
		endcase
	end

	assign pwmTick   = timerHit;
	assign SHDREQ1_N = ~dreq;
	assign PWM_L = {lSample - `S32X_PWM_CENTER, 4'h0};
	assign PWM_R = {rSample - `S32X_PWM_CENTER, 4'h0};

endmodule

`default_nettype wire

// ==== design/pwmFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module pwmFifo #(
	parameter int DEPTH = 3
) (
	input  wire                    CLK,
	input  wire                    RST_N,
	input  wire                    push,
	input  wire                    pop,
	input  wire  [`S32X_PW_W-1:0]  din,
	output logic [`S32X_PW_W-1:0]  head,
	output logic                   full,
	output logic                   empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`S32X_PW_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]      wrPtr;
	logic [PTR_W-1:0]      rdPtr;
	logic [CNT_W-1:0]      count;

	wire doPush = push && !full;  // Dropped when full
	wire doPop  = pop && !empty;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)  rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop) count <= count + 1'b1;
			else if (doPop && !doPush) count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush) mem[wrPtr] <= din;
	end

	assign head  = mem[rdPtr];
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== design/irqCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module irqCtrl (
	input  wire                CLK,
	input  wire                RST_N,
	input  wire                VDP_VINT,
	input  wire                VDP_HINT,
	input  wire                pwmTick,

	shRegIf.irq                regBus,

	output s32xPkg::irqLevelT  SHMIRL_N,
	output s32xPkg::irqLevelT  SHSIRL_N
);

	localparam logic [7:0] IMR_MASK = `S32X_IMR_MASK;

	logic [3:0]   maskNib [2]; // Index 0 master, 1 slave
	logic         hen;         // Shared by both CPUs
	s32xPkg::imrT imrView [2];
	logic [7:0]   hcntr;
	logic [7:0]   lineCnt;
	logic         vintR;
	logic         vintOld;
	logic         hintR;
	logic         hintOld;
	logic [1:0]   vPend;
	logic [1:0]   hPend;
	logic [1:0]   pwmPend;

	wire vRise = vintR & ~vintOld;
	wire hRise = hintR & ~hintOld;
	wire lowWr = regBus.wr && regBus.beL;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			imrView[i] = s32xPkg::imrT'({hen, 3'b000, maskNib[i]});
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			maskNib[0] <= '0;
			maskNib[1] <= '0;
			hen <= 1'b0;
			hcntr <= '0;
			lineCnt <= '0;
			vintR <= 1'b0;
			vintOld <= 1'b0;
			hintR <= 1'b0;
			hintOld <= 1'b0;
			vPend <= '0;
			hPend <= '0;
			pwmPend <= '0;
		end else begin
			vintR <= VDP_VINT;
			vintOld <= vintR;
			hintR <= VDP_HINT;
			hintOld <= hintR;

			if (lowWr && regBus.ofs == `S32X_OFS_IMR) begin
				maskNib[regBus.slv] <= regBus.wdata[3:0] & IMR_MASK[3:0];
				hen <= regBus.wdata[7] & IMR_MASK[7];
			end
			if (lowWr && regBus.ofs == `S32X_OFS_HCNTR) hcntr <= regBus.wdata[7:0];

			// Clears only touch the accessing CPU
			if (regBus.wr) begin
				case (regBus.ofs)
					`S32X_OFS_VCLR:   vPend[regBus.slv] <= 1'b0;
					`S32X_OFS_HCLR:   hPend[regBus.slv] <= 1'b0;
					`S32X_OFS_PWMCLR: pwmPend[regBus.slv] <= 1'b0;
					default: ;
				endcase
			end

			if (hRise) begin
				if (lineCnt == hcntr) begin
					lineCnt <= '0;
					for (int i = 0; i < 2; i++) begin
						if (imrView[i].h && (hen || !vintR)) hPend[i] <= 1'b1; // HEN allows H in vblank
					end
				end else begin
					lineCnt <= lineCnt + 8'd1;
				end
			end

			for (int i = 0; i < 2; i++) begin
				if (vRise && imrView[i].v) vPend[i] <= 1'b1;
				if (pwmTick && imrView[i].pwm) pwmPend[i] <= 1'b1;
			end
		end
	end

	always_comb begin
		case (regBus.ofs)
			`S32X_OFS_IMR:   regBus.irqRdata = {8'h00, imrView[regBus.slv]};
			`S32X_OFS_HCNTR: regBus.irqRdata = {8'h00, hcntr};
			default:         regBus.irqRdata = '0;
		endcase
	end

	function automatic s32xPkg::irqLevelT encLevel(input logic v, input logic h, input logic p);
		if (v)      return s32xPkg::IRQ_V;
		else if (h) return s32xPkg::IRQ_H;
		else if (p) return s32xPkg::IRQ_PWM;
		else        return s32xPkg::IRQ_NONE;
	endfunction

	assign SHMIRL_N = encLevel(vPend[0], hPend[0], pwmPend[0]);
	assign SHSIRL_N = encLevel(vPend[1], hPend[1], pwmPend[1]);

endmodule

`default_nettype wire

// ==== design/shBusDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

module shBusDecoder (
	input  wire                     CLK,
	input  wire                     RST_N,
	input  wire                     CE_R,
	input  wire                     CE_F,

	input  wire              [17:1] SHA,
	input  wire [`S32X_DATA_W-1:0]  SHDI,
	output logic [`S32X_DATA_W-1:0] SHDO,
	input  wire                     SHCS0M_N,
	input  wire                     SHCS0S_N,
	input  wire                     SHBS_N,
	input  wire                     SHRD_WR_N,
	input  wire                     SHRD_N,
	input  wire                     SHDQMLL_N,
	input  wire                     SHDQMLU_N,

	shRegIf.master                  regBus
);

	logic access;

	// 4000-40FF in either CS0 space
	wire sysRegSel = (~SHCS0M_N | ~SHCS0S_N) & (SHA[17:8] == 10'h040);

	wire wrCyc = !SHRD_WR_N && (!SHDQMLL_N || !SHDQMLU_N) && CE_F;
	wire rdCyc = SHRD_WR_N && !SHRD_N && CE_R;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			access <= 1'b0;
			regBus.wr <= 1'b0;
			regBus.rd <= 1'b0;
		end else begin
			regBus.wr <= 1'b0;
			regBus.rd <= 1'b0;
			if (!SHBS_N && CE_F) access <= sysRegSel;
			if (access) begin
				if (wrCyc) begin
					regBus.wr <= 1'b1;
					access <= 1'b0;
				end else if (rdCyc) begin
					regBus.rd <= 1'b1;
					access <= 1'b0;
				end
			end
		end
	end

	// Access payload for the strobe cycle
	always_ff @(posedge CLK) begin
		if (access && (wrCyc || rdCyc)) begin
			regBus.ofs <= SHA[5:1];
			regBus.beL <= !SHDQMLL_N;
			regBus.beU <= !SHDQMLU_N;
			regBus.wdata <= SHDI;
			regBus.slv <= !SHCS0S_N;
		end
		if (regBus.rd) SHDO <= regBus.irqRdata | regBus.pwmRdata; // Units return 0 when not hit
	end

endmodule

`default_nettype wire

// ==== design/shRegIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s32x_config.svh"

interface shRegIf;
	logic                   wr;
	logic                   rd;
	logic [`S32X_OFS_W-1:0] ofs;
	logic                   beL;
	logic                   beU;
	logic [`S32X_DATA_W-1:0] wdata;
	logic                   slv;     // Slave CPU access
	logic [`S32X_DATA_W-1:0] irqRdata;
	logic [`S32X_DATA_W-1:0] pwmRdata;

	modport master (output wr, rd, ofs, beL, beU, wdata, slv, input irqRdata, pwmRdata);

	modport irq (input wr, rd, ofs, beL, beU, wdata, slv, output irqRdata);

	modport pwm (input wr, rd, ofs, beL, beU, wdata, slv, output pwmRdata);

endinterface

`default_nettype wire

// ==== design/s32xPkg.sv ====
`default_nettype none

`include "s32x_config.svh"

package s32xPkg;

	// Interrupt mask, bit 1 was CMD and reads zero
	typedef struct packed {
		logic       hen;
		logic [2:0] rsvHi;
		logic       v;
		logic       h;
		logic       rsvLo;
		logic       pwm;
	} imrT;

	typedef struct packed {
		logic [3:0] rsvHi;
		logic [3:0] tm;    // Timer interval, 0 means 16
		logic       rtp;
		logic [2:0] rsvLo;
		logic [1:0] rmd;
		logic [1:0] lmd;
	} pwmcrT;

	typedef struct packed {
		logic                  full;
		logic                  empty;
		logic [1:0]            rsv;
		logic [`S32X_PW_W-1:0] pw;
	} pwrT;

	// Active-low level code driven to the CPU
	typedef enum logic [2:0] {
		IRQ_V    = 3'b001, // Level 12
		IRQ_H    = 3'b010, // Level 10
		IRQ_PWM  = 3'b100, // Level 6
		IRQ_NONE = 3'b111
	} irqLevelT;

endpackage

`default_nettype wire

// ==== design/s32x_config.svh ====
`ifndef S32X_CONFIG_SVH
`define S32X_CONFIG_SVH

`define S32X_DATA_W      16
`define S32X_OFS_W       5       // SHA[5:1]
`define S32X_PW_W        12
`define S32X_PWM_DEPTH   3
`define S32X_PWM_CENTER  12'h800 // Zero output level

// Word offsets of the byte addresses in the comments
`define S32X_OFS_IMR     5'h00   // 00
`define S32X_OFS_HCNTR   5'h02   // 04
`define S32X_OFS_VCLR    5'h0B   // 16
`define S32X_OFS_HCLR    5'h0C   // 18
`define S32X_OFS_PWMCLR  5'h0E   // 1C
`define S32X_OFS_PWMCR   5'h18   // 30
`define S32X_OFS_CYCR    5'h19   // 32
`define S32X_OFS_LPW     5'h1A   // 34
`define S32X_OFS_RPW     5'h1B   // 36
`define S32X_OFS_MPW     5'h1C   // 38

`define S32X_IMR_MASK    8'h8D
`define S32X_PWMCR_MASK  16'h0F8F
`define S32X_CYCR_MASK   16'h0FFF
`define S32X_PWR_MASK    16'h0FFF

`endif
